//--- design/boot_ctr.sv
`default_nettype none
`timescale 1ns/10ps

module boot_ctr import int_mem_pkg::*; (
   input  wire                  clk_i,
   input  wire                  reset_i,
   output logic                 boot_o,
   output logic                 cpu_reset_o,

   // boot control register
   input  wire                  reg_valid_i,
   input  wire [DATA_W-1:0]     reg_wdata_i,
   input  wire [STRB_W-1:0]     reg_wstrb_i,
   output logic [DATA_W-1:0]    reg_rdata_o,
   output logic                 reg_ready_o,

   // copy writes into sram
   output logic                 sram_valid_o,
   output logic [ADDR_W-1:0]    sram_addr_o,
   output logic [DATA_W-1:0]    sram_wdata_o,
   output logic [STRB_W-1:0]    sram_wstrb_o
);

   typedef enum logic [1:0] {ST_COPY, ST_RUN_BOOT, ST_RESTART, ST_RUN} state_t;

   state_t                             state;
   logic [BOOT_IDX_W:0]                copy_cnt;
   logic                               rd_active;
   logic                               wr_valid;
   logic [BOOT_IDX_W-1:0]              wr_idx;
   logic [$clog2(CPU_RST_CYCLES)-1:0]  rst_cnt;
   logic                               clear_boot;

   // rom reads run until the counter msb sets
   assign rd_active = (state == ST_COPY) && !copy_cnt[BOOT_IDX_W];

   // boot mode can only be cleared, by a write of 0
   assign clear_boot = (state == ST_RUN_BOOT) && reg_valid_i && (|reg_wstrb_i)
                       && !reg_wdata_i[0];

   boot_rom rom0 (
      .clk_i   (clk_i),
      .addr_i  (copy_cnt[BOOT_IDX_W-1:0]),
      .rdata_o (sram_wdata_o)
   );

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state <= ST_COPY;
         copy_cnt <= '0;
         wr_valid <= 1'b0;
         rst_cnt <= '0;
      end else begin
         wr_valid <= rd_active;
         if (rd_active) begin
            copy_cnt <= copy_cnt + 1'b1;
         end
         case (state)
            ST_COPY: begin
               // last write has gone out
               if (copy_cnt[BOOT_IDX_W] && !wr_valid) begin
                  state <= ST_RUN_BOOT;
               end
            end
            ST_RUN_BOOT: begin
               if (clear_boot) begin
                  state <= ST_RESTART;
                  rst_cnt <= ($clog2(CPU_RST_CYCLES))'(CPU_RST_CYCLES - 1);
               end
            end
            ST_RESTART: begin
               if (rst_cnt == '0) begin
                  state <= ST_RUN;
               end else begin
                  rst_cnt <= rst_cnt - 1'b1;
               end
            end
            default: state <= ST_RUN;
         endcase
      end
   end

   // word index follows the rom address by one cycle
   always_ff @(posedge clk_i) begin
      wr_idx <= copy_cnt[BOOT_IDX_W-1:0];
   end

   assign sram_valid_o = wr_valid;
   assign sram_addr_o = ADDR_W'(BOOT_OFFSET) + ADDR_W'({wr_idx, 2'b00});
   assign sram_wstrb_o = {STRB_W{wr_valid}};

   assign boot_o = (state == ST_COPY) || (state == ST_RUN_BOOT);
   assign cpu_reset_o = (state == ST_COPY) || (state == ST_RESTART);

   // register reads see boot mode at request time
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         reg_ready_o <= 1'b0;
      end else begin
         reg_ready_o <= reg_valid_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reg_valid_i) begin
         reg_rdata_o <= {{(DATA_W-1){1'b0}}, boot_o};
      end
   end

endmodule

`default_nettype wire

//--- design/boot_rom.sv
`default_nettype none
`timescale 1ns/10ps

module boot_rom import int_mem_pkg::*; (
   input  wire                    clk_i,
   input  wire [BOOT_IDX_W-1:0]   addr_i,
   output logic [DATA_W-1:0]      rdata_o
);

   logic [DATA_W-1:0] rom [BOOT_WORDS];

   // image comes from the package function, no hex file
   initial begin
      for (int k = 0; k < BOOT_WORDS; k++) begin
         rom[k] = boot_word(k);
      end
   end

   // registered read, data one cycle after address
   always_ff @(posedge clk_i) begin
      rdata_o <= rom[addr_i];
   end

endmodule

`default_nettype wire

//--- design/bus_merge.sv
`default_nettype none
`timescale 1ns/10ps

module bus_merge import int_mem_pkg::*; (
   input  wire                  clk_i,
   input  wire                  reset_i,

   // write master, boot copy
   input  wire                  w_valid_i,
   input  wire [ADDR_W-1:0]     w_addr_i,
   input  wire [DATA_W-1:0]     w_wdata_i,
   input  wire [STRB_W-1:0]     w_wstrb_i,

   // read master, cpu instruction fetch
   input  wire                  r_valid_i,
   input  wire [ADDR_W-1:0]     r_addr_i,
   output logic [DATA_W-1:0]    r_rdata_o,
   output logic                 r_ready_o,

   // merged slave port
   output logic                 s_valid_o,
   output logic [ADDR_W-1:0]    s_addr_o,
   output logic [DATA_W-1:0]    s_wdata_o,
   output logic [STRB_W-1:0]    s_wstrb_o,
   input  wire [DATA_W-1:0]     s_rdata_i,
   input  wire                  s_ready_i
);

   logic r_gnt;
   logic r_gnt_q;

   // write master always wins
   assign r_gnt = r_valid_i && !w_valid_i;

   assign s_valid_o = w_valid_i || r_valid_i;
   assign s_addr_o = w_valid_i ? w_addr_i : r_addr_i;
   assign s_wdata_o = w_wdata_i;

   // reads carry no strobes
   assign s_wstrb_o = w_valid_i ? w_wstrb_i : '0;

   // remember who owns the next response
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         r_gnt_q <= 1'b0;
      end else begin
         r_gnt_q <= r_gnt;
      end
   end

   // a lost fetch gets no ready
   assign r_ready_o = r_gnt_q && s_ready_i;
   assign r_rdata_o = s_rdata_i;

endmodule

`default_nettype wire

//--- design/bus_split.sv
`default_nettype none
`timescale 1ns/10ps

module bus_split import int_mem_pkg::*; (
   input  wire                  clk_i,
   input  wire                  reset_i,

   // master side, cpu data bus
   input  wire                  m_valid_i,
   input  wire [ADDR_W-1:0]     m_addr_i,
   input  wire [DATA_W-1:0]     m_wdata_i,
   input  wire [STRB_W-1:0]     m_wstrb_i,
   output logic [DATA_W-1:0]    m_rdata_o,
   output logic                 m_ready_o,

   // slave 0, sram
   output logic                 s0_valid_o,
   output logic [ADDR_W-1:0]    s0_addr_o,
   output logic [DATA_W-1:0]    s0_wdata_o,
   output logic [STRB_W-1:0]    s0_wstrb_o,
   input  wire [DATA_W-1:0]     s0_rdata_i,
   input  wire                  s0_ready_i,

   // slave 1, boot controller register
   output logic                 s1_valid_o,
   output logic [DATA_W-1:0]    s1_wdata_o,
   output logic [STRB_W-1:0]    s1_wstrb_o,
   input  wire [DATA_W-1:0]     s1_rdata_i,
   input  wire                  s1_ready_i
);

   logic sel;
   logic sel_q;

   assign sel = m_addr_i[B_BIT];

   // only the addressed slave sees the strobe
   assign s0_valid_o = m_valid_i && !sel;
   assign s1_valid_o = m_valid_i && sel;

   assign s0_addr_o = m_addr_i;
   assign s0_wdata_o = m_wdata_i;
   assign s0_wstrb_o = m_wstrb_i;
   assign s1_wdata_o = m_wdata_i;
   assign s1_wstrb_o = m_wstrb_i;

   // hold the target for the response cycle
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         sel_q <= 1'b0;
      end else if (m_valid_i) begin
         sel_q <= sel;
      end
   end

   assign m_rdata_o = sel_q ? s1_rdata_i : s0_rdata_i;
   assign m_ready_o = sel_q ? s1_ready_i : s0_ready_i;

endmodule

`default_nettype wire

//--- design/dp_sram.sv
`default_nettype none
`timescale 1ns/10ps

module dp_sram import int_mem_pkg::*; (
   input  wire                  clk_i,

   // port a
   input  wire                  a_valid_i,
   input  wire [SRAM_IDX_W-1:0] a_addr_i,
   input  wire [DATA_W-1:0]     a_wdata_i,
   input  wire [STRB_W-1:0]     a_wstrb_i,
   output logic [DATA_W-1:0]    a_rdata_o,
   output logic                 a_ready_o,

   // port b
   input  wire                  b_valid_i,
   input  wire [SRAM_IDX_W-1:0] b_addr_i,
   input  wire [DATA_W-1:0]     b_wdata_i,
   input  wire [STRB_W-1:0]     b_wstrb_i,
   output logic [DATA_W-1:0]    b_rdata_o,
   output logic                 b_ready_o
);

   logic [DATA_W-1:0] mem [SRAM_WORDS];

   // both ports in one block, same word same cycle is undefined
   always_ff @(posedge clk_i) begin
      if (a_valid_i) begin
         for (int i = 0; i < STRB_W; i++) begin
            if (a_wstrb_i[i]) begin
               mem[a_addr_i][i*8 +: 8] <= a_wdata_i[i*8 +: 8];
            end
         end
      end
      if (b_valid_i) begin
         for (int i = 0; i < STRB_W; i++) begin
            if (b_wstrb_i[i]) begin
               mem[b_addr_i][i*8 +: 8] <= b_wdata_i[i*8 +: 8];
            end
         end
      end
   end

   // registered reads, old data on a write
   always_ff @(posedge clk_i) begin
      if (a_valid_i) begin
         a_rdata_o <= mem[a_addr_i];
      end
      if (b_valid_i) begin
         b_rdata_o <= mem[b_addr_i];
      end
   end

   // fixed one cycle latency
   always_ff @(posedge clk_i) begin
      a_ready_o <= a_valid_i;
      b_ready_o <= b_valid_i;
   end

endmodule

`default_nettype wire

//--- design/int_mem.sv
`default_nettype none
`timescale 1ns/10ps

module int_mem import int_mem_pkg::*; (
   input  wire                  clk_i,
   input  wire                  reset_i,
   output logic                 boot_o,
   output logic                 cpu_reset_o,

   // instruction bus, read only
   input  wire                  i_valid_i,
   input  wire [ADDR_W-1:0]     i_addr_i,
   output logic [DATA_W-1:0]    i_rdata_o,
   output logic                 i_ready_o,

   // data bus
   input  wire                  d_valid_i,
   input  wire [ADDR_W-1:0]     d_addr_i,
   input  wire [DATA_W-1:0]     d_wdata_i,
   input  wire [STRB_W-1:0]     d_wstrb_i,
   output logic [DATA_W-1:0]    d_rdata_o,
   output logic                 d_ready_o
);

   // sram half of the data bus
   logic                 ram_d_valid;
   logic [ADDR_W-1:0]    ram_d_addr;
   logic [ADDR_W-1:0]    ram_d_addr_off;
   logic [DATA_W-1:0]    ram_d_wdata;
   logic [STRB_W-1:0]    ram_d_wstrb;
   logic [DATA_W-1:0]    ram_d_rdata;
   logic                 ram_d_ready;

   // boot controller register
   logic                 reg_valid;
   logic [DATA_W-1:0]    reg_wdata;
   logic [STRB_W-1:0]    reg_wstrb;
   logic [DATA_W-1:0]    reg_rdata;
   logic                 reg_ready;

   // boot copy writes
   logic                 cp_valid;
   logic [ADDR_W-1:0]    cp_addr;
   logic [DATA_W-1:0]    cp_wdata;
   logic [STRB_W-1:0]    cp_wstrb;

   // merged instruction port
   logic [ADDR_W-1:0]    i_addr_off;
   logic                 ram_i_valid;
   logic [ADDR_W-1:0]    ram_i_addr;
   logic [DATA_W-1:0]    ram_i_wdata;
   logic [STRB_W-1:0]    ram_i_wstrb;
   logic [DATA_W-1:0]    ram_i_rdata;
   logic                 ram_i_ready;

   bus_split data_split (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .m_valid_i  (d_valid_i),
      .m_addr_i   (d_addr_i),
      .m_wdata_i  (d_wdata_i),
      .m_wstrb_i  (d_wstrb_i),
      .m_rdata_o  (d_rdata_o),
      .m_ready_o  (d_ready_o),
      .s0_valid_o (ram_d_valid),
      .s0_addr_o  (ram_d_addr),
      .s0_wdata_o (ram_d_wdata),
      .s0_wstrb_o (ram_d_wstrb),
      .s0_rdata_i (ram_d_rdata),
      .s0_ready_i (ram_d_ready),
      .s1_valid_o (reg_valid),
      .s1_wdata_o (reg_wdata),
      .s1_wstrb_o (reg_wstrb),
      .s1_rdata_i (reg_rdata),
      .s1_ready_i (reg_ready)
   );

   boot_ctr boot_ctr0 (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .boot_o       (boot_o),
      .cpu_reset_o  (cpu_reset_o),
      .reg_valid_i  (reg_valid),
      .reg_wdata_i  (reg_wdata),
      .reg_wstrb_i  (reg_wstrb),
      .reg_rdata_o  (reg_rdata),
      .reg_ready_o  (reg_ready),
      .sram_valid_o (cp_valid),
      .sram_addr_o  (cp_addr),
      .sram_wdata_o (cp_wdata),
      .sram_wstrb_o (cp_wstrb)
   );

   // in boot mode the cpu sees the boot image at address zero
   assign i_addr_off = boot_o ? i_addr_i + ADDR_W'(BOOT_OFFSET) : i_addr_i;
   assign ram_d_addr_off = boot_o ? ram_d_addr + ADDR_W'(BOOT_OFFSET) : ram_d_addr;

   bus_merge ibus_merge (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .w_valid_i (cp_valid),
      .w_addr_i  (cp_addr),
      .w_wdata_i (cp_wdata),
      .w_wstrb_i (cp_wstrb),
      .r_valid_i (i_valid_i),
      .r_addr_i  (i_addr_off),
      .r_rdata_o (i_rdata_o),
      .r_ready_o (i_ready_o),
      .s_valid_o (ram_i_valid),
      .s_addr_o  (ram_i_addr),
      .s_wdata_o (ram_i_wdata),
      .s_wstrb_o (ram_i_wstrb),
      .s_rdata_i (ram_i_rdata),
      .s_ready_i (ram_i_ready)
   );

   // word addresses, bits above the sram size drop out
   dp_sram int_sram (
      .clk_i     (clk_i),
      .a_valid_i (ram_i_valid),
      .a_addr_i  (ram_i_addr[SRAM_ADDR_W-1:2]),
      .a_wdata_i (ram_i_wdata),
      .a_wstrb_i (ram_i_wstrb),
      .a_rdata_o (ram_i_rdata),
      .a_ready_o (ram_i_ready),
      .b_valid_i (ram_d_valid),
      .b_addr_i  (ram_d_addr_off[SRAM_ADDR_W-1:2]),
      .b_wdata_i (ram_d_wdata),
      .b_wstrb_i (ram_d_wstrb),
      .b_rdata_o (ram_d_rdata),
      .b_ready_o (ram_d_ready)
   );

endmodule

`default_nettype wire

//--- design/int_mem_pkg.sv
`default_nettype none

package int_mem_pkg;

   // bus widths
   localparam int DATA_W = 32;
   localparam int ADDR_W = 16;
   localparam int STRB_W = DATA_W / 8;

   // on-chip sram, 4 KiB
   localparam int SRAM_ADDR_W = 12;
   localparam int SRAM_IDX_W = SRAM_ADDR_W - 2;
   localparam int SRAM_WORDS = 2 ** SRAM_IDX_W;

   // boot rom, 256 bytes
   localparam int BOOTROM_ADDR_W = 8;
   localparam int BOOT_IDX_W = BOOTROM_ADDR_W - 2;
   localparam int BOOT_WORDS = 2 ** BOOT_IDX_W;

   // data bus address bit that selects the boot controller
   localparam int B_BIT = 15;

   // boot image sits in the top of the sram
   localparam int BOOT_OFFSET = (2 ** SRAM_ADDR_W) - (2 ** BOOTROM_ADDR_W);

   // cpu reset pulse after leaving boot mode
   localparam int CPU_RST_CYCLES = 8;

   // boot program image, one word per index
   function automatic logic [DATA_W-1:0] boot_word(input int unsigned i);
      logic [DATA_W-1:0] step;
      step = DATA_W'(i) * 32'h0000_0101;
      return 32'hB007_0000 + step;
   endfunction

endpackage

`default_nettype wire

//--- flist.f
design/int_mem_pkg.sv
design/boot_rom.sv
design/boot_ctr.sv
design/bus_split.sv
design/bus_merge.sv
design/dp_sram.sv
design/int_mem.sv
sim/int_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the int_mem testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module int_mem_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vint_mem_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Result: PASSED"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- sim/int_mem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module int_mem_tb import int_mem_pkg::*; ();

   localparam int CLK_PERIOD = 4;
   localparam int RAND_N = 120;
   localparam logic [ADDR_W-1:0] REG_ADDR = ADDR_W'(1 << B_BIT);
   // worst case per phase, every bus access takes two cycles
   localparam int TEST_CYCLES = 5 + BOOT_WORDS + 4 + 2 * BOOT_WORDS + 40
                                + 4 * CPU_RST_CYCLES + 20 + 20 + 4 * RAND_N;

   logic                 clk_i;
   logic                 reset_i;
   logic                 boot_o;
   logic                 cpu_reset_o;
   logic                 i_valid_i;
   logic [ADDR_W-1:0]    i_addr_i;
   logic [DATA_W-1:0]    i_rdata_o;
   logic                 i_ready_o;
   logic                 d_valid_i;
   logic [ADDR_W-1:0]    d_addr_i;
   logic [DATA_W-1:0]    d_wdata_i;
   logic [STRB_W-1:0]    d_wstrb_i;
   logic [DATA_W-1:0]    d_rdata_o;
   logic                 d_ready_o;

   // expected sram contents, indexed by word
   logic [DATA_W-1:0]    model [SRAM_WORDS];
   logic [31:0]          lcg_state;
   int                   errors;
   int                   checks;

   int_mem dut (.*);

   always #(CLK_PERIOD / 2) clk_i = !clk_i;

   initial begin
      #(4 * TEST_CYCLES * CLK_PERIOD);
      $display("watchdog timeout after %0d cycles, the tests did not finish", 4 * TEST_CYCLES);
      $display("Result: FAILED");
      $finish;
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                     input logic [DATA_W-1:0] new_w,
                                                     input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] res;
      res = old_w;
      for (int i = 0; i < STRB_W; i++) begin
         if (strb[i]) begin
            res[i*8 +: 8] = new_w[i*8 +: 8];
         end
      end
      return res;
   endfunction

   // cpu byte address to sram word, boot mode moves it up
   function automatic logic [SRAM_IDX_W-1:0] word_index(input logic [ADDR_W-1:0] addr,
                                                       input logic boot);
      logic [ADDR_W-1:0] phys;
      phys = boot ? addr + ADDR_W'(BOOT_OFFSET) : addr;
      return phys[SRAM_ADDR_W-1:2];
   endfunction

   task automatic model_write(input logic [ADDR_W-1:0] addr, input logic boot,
                              input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb);
      logic [SRAM_IDX_W-1:0] idx;
      idx = word_index(addr, boot);
      model[idx] = merge_bytes(model[idx], wdata, strb);
   endtask

   task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                             input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
      end
   endtask

   // called just after a rising edge, returns two cycles later
   task automatic fetch(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] rdata);
      check_bit(i_ready_o, 1'b0, "instruction ready before request");
      i_valid_i = 1'b1;
      i_addr_i = addr;
      @(posedge clk_i);
      #1;
      check_bit(i_ready_o, 1'b1, "instruction ready one cycle after valid");
      rdata = i_rdata_o;
      i_valid_i = 1'b0;
      i_addr_i = '0;
      @(posedge clk_i);
      #1;
      check_bit(i_ready_o, 1'b0, "instruction ready held past one cycle");
   endtask

   task automatic data_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                              input logic [STRB_W-1:0] strb, output logic [DATA_W-1:0] rdata);
      check_bit(d_ready_o, 1'b0, "data ready before request");
      d_valid_i = 1'b1;
      d_addr_i = addr;
      d_wdata_i = wdata;
      d_wstrb_i = strb;
      @(posedge clk_i);
      #1;
      check_bit(d_ready_o, 1'b1, "data ready one cycle after valid");
      rdata = d_rdata_o;
      d_valid_i = 1'b0;
      d_wstrb_i = '0;
      @(posedge clk_i);
      #1;
      check_bit(d_ready_o, 1'b0, "data ready held past one cycle");
   endtask

   task automatic fetch_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
      logic [DATA_W-1:0] rdata;
      fetch(addr, rdata);
      check_word(rdata, exp, $sformatf("fetch at %h", addr));
   endtask

   task automatic data_read_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
      logic [DATA_W-1:0] rdata;
      data_access(addr, '0, '0, rdata);
      check_word(rdata, exp, $sformatf("data read at %h", addr));
   endtask

   task automatic test_reset_copy();
      int cycles;
      check_bit(boot_o, 1'b1, "boot_o after reset");
      check_bit(cpu_reset_o, 1'b1, "cpu_reset_o after reset");
      cycles = 0;
      while (cpu_reset_o && cycles < BOOT_WORDS + 4) begin
         @(posedge clk_i);
         #1;
         cycles++;
      end
      if (cpu_reset_o) begin
         errors++;
         $display("cpu reset still high %0d cycles after reset, boot copy did not end", cycles);
      end
      // boot image should now sit at address zero as the cpu sees it
      for (int k = 0; k < BOOT_WORDS; k++) begin
         model[word_index(ADDR_W'(4 * k), 1'b1)] = boot_word(k);
         fetch_check(ADDR_W'(4 * k), boot_word(k));
      end
   endtask

   task automatic test_boot_data();
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [DATA_W-1:0] rdata;
      logic [STRB_W-1:0] strb;
      logic [31:0]       r;
      addr = 16'h0040;
      wdata = next_rand();
      data_access(addr, wdata, '1, rdata);
      model_write(addr, 1'b1, wdata, '1);
      fetch_check(addr, model[word_index(addr, 1'b1)]);
      for (int k = 0; k < 4; k++) begin
         addr = ADDR_W'(16'h0080 + 4 * k);
         wdata = next_rand();
         data_access(addr, wdata, '1, rdata);
         model_write(addr, 1'b1, wdata, '1);
         r = next_rand();
         strb = r[STRB_W-1:0];
         if (strb == '0 || strb == '1) begin
            strb = 4'b0101;
         end
         wdata = next_rand();
         data_access(addr, wdata, strb, rdata);
         model_write(addr, 1'b1, wdata, strb);
         data_read_check(addr, model[word_index(addr, 1'b1)]);
         fetch_check(addr, model[word_index(addr, 1'b1)]);
      end
   endtask

   task automatic test_boot_reg();
      int cycles;
      logic [DATA_W-1:0] rdata;
      data_read_check(REG_ADDR, 32'h0000_0001);
      // register write done by hand, the pulse starts on its edge
      d_valid_i = 1'b1;
      d_addr_i = REG_ADDR;
      d_wdata_i = '0;
      d_wstrb_i = '1;
      @(posedge clk_i);
      #1;
      check_bit(d_ready_o, 1'b1, "boot register write ready");
      d_valid_i = 1'b0;
      d_wstrb_i = '0;
      check_bit(boot_o, 1'b0, "boot_o after clearing boot mode");
      cycles = 0;
      while (cpu_reset_o && cycles < 4 * CPU_RST_CYCLES) begin
         cycles++;
         @(posedge clk_i);
         #1;
      end
      check_word(DATA_W'(cycles), DATA_W'(CPU_RST_CYCLES), "cpu reset pulse length in cycles");
      data_access(REG_ADDR, '0, '0, rdata);
      check_word(rdata, '0, "boot register read after restart");
   endtask

   task automatic test_run_map();
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [DATA_W-1:0] rdata;
      check_bit(boot_o, 1'b0, "boot_o in run mode");
      fetch_check(ADDR_W'(BOOT_OFFSET), boot_word(0));
      addr = 16'h0010;
      wdata = next_rand();
      data_access(addr, wdata, '1, rdata);
      model_write(addr, 1'b0, wdata, '1);
      fetch_check(addr, model[word_index(addr, 1'b0)]);
      data_read_check(addr, model[word_index(addr, 1'b0)]);
      // word written through the offset in boot mode
      addr = ADDR_W'(BOOT_OFFSET + 16'h0040);
      data_read_check(addr, model[word_index(addr, 1'b0)]);
   endtask

   task automatic test_random();
      logic [ADDR_W-1:0] waddr;
      logic [ADDR_W-1:0] raddr;
      logic [DATA_W-1:0] wdata;
      logic [DATA_W-1:0] rdata;
      logic [DATA_W-1:0] dummy;
      logic [DATA_W-1:0] exp;
      logic [31:0]       r;
      int unsigned       pick;
      logic [ADDR_W-1:0] written [$];
      for (int n = 0; n < RAND_N; n++) begin
         r = next_rand();
         waddr = ADDR_W'((r % 32'(BOOT_OFFSET / 4)) * 32'd4);
         wdata = next_rand();
         r = next_rand();
         pick = {8'h00, r[31:8]};
         if (written.size() > 0 && r[0]) begin
            raddr = written[pick % written.size()];
         end else begin
            raddr = ADDR_W'(32'(BOOT_OFFSET) + ({24'h0, r[15:8]} % 32'(BOOT_WORDS)) * 32'd4);
         end
         if (word_index(raddr, 1'b0) == word_index(waddr, 1'b0)) begin
            raddr = ADDR_W'(BOOT_OFFSET);
         end
         exp = model[word_index(raddr, 1'b0)];
         fork
            data_access(waddr, wdata, '1, dummy);
            fetch(raddr, rdata);
         join
         check_word(rdata, exp, $sformatf("random fetch at %h", raddr));
         model_write(waddr, 1'b0, wdata, '1);
         written.push_back(waddr);
      end
      // read everything back over the data port
      foreach (written[i]) begin
         data_read_check(written[i], model[word_index(written[i], 1'b0)]);
      end
   endtask

   initial begin
      clk_i = 1'b0;
      reset_i = 1'b1;
      i_valid_i = 1'b0;
      i_addr_i = '0;
      d_valid_i = 1'b0;
      d_addr_i = '0;
      d_wdata_i = '0;
      d_wstrb_i = '0;
      lcg_state = 32'h45c8_de82;
      errors = 0;
      checks = 0;
      repeat (5) @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      test_reset_copy();
      test_boot_data();
      test_boot_reg();
      test_run_map();
      test_random();
      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
